// File: source/period_report.sv
// report collector for finished measurements
// one slot per channel, round-robin scan, sent out against credits
`timescale 1ns/1ns

module period_report import stb_pkg::*; (
	input  logic              clk_i,
	input  logic              arstn_i,
	input  logic [N_CHAN-1:0] meas_valid_i,
	input  t_cnt_t            meas_period_i [N_CHAN],
	input  logic              rpt_credit_i,
	output logic              rpt_valid_o,
	output chan_id_t          rpt_chan_o,
	output t_cnt_t            rpt_period_o
);

	logic [N_CHAN-1:0]       pend_q;
	t_cnt_t                  period_q [N_CHAN];
	chan_id_t                ptr_q;
	logic [CREDIT_WIDTH-1:0] credit_cnt_q;
	logic [CREDIT_WIDTH-1:0] credit_free;
	chan_id_t                scan_idx;
	chan_id_t                pick_idx;
	logic                    pick_found;
	logic                    send;

	// ------------------------------
	// per-channel slots
	// ------------------------------
	// a new measurement overwrites a waiting one
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			pend_q <= '0;
		end else begin
			for (int i = 0; i < N_CHAN; i++) begin
				if (meas_valid_i[i]) begin
					pend_q[i] <= 1'b1;
				end else if (send && (pick_idx == chan_id_t'(i))) begin
					pend_q[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		for (int i = 0; i < N_CHAN; i++) begin
			if (meas_valid_i[i]) begin
				period_q[i] <= meas_period_i[i];
			end
		end
	end

	// ------------------------------
	// round-robin pick
	// ------------------------------
	always_comb begin
		pick_found = 1'b0;
		pick_idx   = ptr_q;
		scan_idx   = ptr_q;
		for (int i = 0; i < N_CHAN; i++) begin
			scan_idx = chan_id_t'((int'(ptr_q) + i) % N_CHAN);
			if (!pick_found && pend_q[scan_idx]) begin
				pick_found = 1'b1;
				pick_idx   = scan_idx;
			end
		end
	end

	// the credit of a report on the output is taken when the pulse ends
	assign credit_free = credit_cnt_q - CREDIT_WIDTH'(rpt_valid_o);
	assign send        = pick_found && (credit_free != '0);

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			credit_cnt_q <= CREDIT_WIDTH'(CREDIT_INIT);
			rpt_valid_o  <= 1'b0;
			ptr_q        <= '0;
		end else begin
			if (rpt_credit_i && (credit_free != CREDIT_WIDTH'(CREDIT_INIT))) begin
				credit_cnt_q <= credit_free + 1'b1;
			end else begin
				credit_cnt_q <= credit_free;
			end
			rpt_valid_o <= send;
			if (send) begin
				ptr_q <= chan_id_t'((int'(pick_idx) + 1) % N_CHAN);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (send) begin
			rpt_chan_o   <= pick_idx;
			rpt_period_o <= period_q[pick_idx];
		end
	end

endmodule

// File: source/pipelined_adder.sv
// two-stage 32-bit adder for deadline arithmetic
// low halves in stage one, high halves plus carry in stage two
`timescale 1ns/1ns

module pipelined_adder import stb_pkg::*; (
	input  logic   clk_i,
	input  logic   arstn_i,
	input  t_cnt_t a_i,
	input  t_cnt_t b_i,
	input  logic   valid_i,
	output logic   valid_o,
	output t_cnt_t res_o
);

	logic [T_HALF_WIDTH-1:0] lo_sum;
	logic                    lo_carry;
	logic [T_HALF_WIDTH-1:0] lo_sum_q;
	logic                    carry_q;
	logic [T_HALF_WIDTH-1:0] a_hi_q;
	logic [T_HALF_WIDTH-1:0] b_hi_q;
	logic [T_HALF_WIDTH-1:0] hi_sum;
	logic                    valid_q;

	assign {lo_carry, lo_sum} = a_i[T_HALF_WIDTH-1:0] + b_i[T_HALF_WIDTH-1:0];
	assign hi_sum = a_hi_q + b_hi_q + {{(T_HALF_WIDTH-1){1'b0}}, carry_q};

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			valid_q <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_q <= valid_i;
			valid_o <= valid_q;
		end
	end

	// stage registers only load with a valid operand, result holds until the next one
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			lo_sum_q <= lo_sum;
			carry_q  <= lo_carry;
			a_hi_q   <= a_i[T_CNT_WIDTH-1:T_HALF_WIDTH];
			b_hi_q   <= b_i[T_CNT_WIDTH-1:T_HALF_WIDTH];
		end
		if (valid_q) begin
			res_o <= {hi_sum, lo_sum_q};
		end
	end

endmodule

// File: source/stb_pkg.sv
// shared definitions of the strobe meter
// widths, channel count, timing limits and channel states

package stb_pkg;

	// ------------------------------
	// widths and counts
	// ------------------------------
	localparam int T_CNT_WIDTH   = 32;
	localparam int T_HALF_WIDTH  = T_CNT_WIDTH / 2;
	localparam int N_CHAN        = 4;
	localparam int CHAN_ID_WIDTH = $clog2(N_CHAN);

	// time stamp or period
	typedef logic [T_CNT_WIDTH-1:0] t_cnt_t;
	typedef logic [CHAN_ID_WIDTH-1:0] chan_id_t;

	// strobe low time at each period boundary
	localparam int ZERO_HOLD_CYCLES = 1;
	// generator arms this many cycles before the first deadline
	localparam int GEN_OFFSET = 4;
	// shortest period the deadline pipeline keeps up with
	localparam int MIN_PERIOD = 16;

	// report flow control
	localparam int CREDIT_INIT  = 4;
	localparam int CREDIT_WIDTH = $clog2(CREDIT_INIT + 1);

	// channel FSM, one-hot
	typedef enum logic [8:0] {
		FIND_EDGE_1     = 9'b0_0000_0001,
		FIND_EDGE_2     = 9'b0_0000_0010,
		WRITE_START     = 9'b0_0000_0100,
		FIND_EDGE_3     = 9'b0_0000_1000,
		COUNT_PERIOD    = 9'b0_0001_0000,
		COUNT_GEN_START = 9'b0_0010_0000,
		WAIT_GEN_START  = 9'b0_0100_0000,
		COUNT_STROBE    = 9'b0_1000_0000,
		WAIT_STB_END    = 9'b1_0000_0000
	} chan_state_e;

endpackage

// File: source/strobe_channel.sv
// one strobe channel
// measures the period of an asynchronous input, then repeats it as a strobe
`timescale 1ns/1ns

module strobe_channel import stb_pkg::*; (
	input  logic   clk_i,
	input  logic   arstn_i,
	input  t_cnt_t t_cnt_i,
	input  logic   sig_i,
	input  logic   rearm_i,
	output logic   stb_o,
	output logic   rdy_o,
	output logic   err_o,
	output logic   meas_valid_o,
	output t_cnt_t meas_period_o
);

	logic [1:0]  sync_q;
	logic        sync_d_q;
	logic        rise_q;

	chan_state_e state_q;
	chan_state_e state_d;

	t_cnt_t      t_start_q;
	t_cnt_t      period_raw;
	logic        period_short;

	// deadline arithmetic
	t_cnt_t      gen_incr;
	t_cnt_t      zh_incr;
	t_cnt_t      end_base;
	logic        gen_launch;
	logic        end_launch;
	logic        zh_launch;
	logic        gen_valid;
	logic        zh_valid;
	t_cnt_t      gen_start_res;
	t_cnt_t      stb_end_res;
	t_cnt_t      zero_hold_res;

	// compare stage
	logic        gen_armed_q;
	logic        zh_armed_q;
	logic        gen_hit_q;
	logic        end_hit_q;
	logic        zh_hit_q;
	logic        gen_on;

	// ------------------------------
	// synchronizer and edge finder
	// ------------------------------
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			sync_q   <= '0;
			sync_d_q <= 1'b0;
			rise_q   <= 1'b0;
		end else begin
			sync_q   <= {sync_q[0], sig_i};
			sync_d_q <= sync_q[1];
			rise_q   <= sync_q[1] & ~sync_d_q;
		end
	end

	// ------------------------------
	// measurement FSM
	// ------------------------------
	always_comb begin
		state_d = state_q;
		if (rearm_i) begin
			state_d = FIND_EDGE_1;
		end else begin
			unique case (state_q)
				FIND_EDGE_1:     if (rise_q) state_d = FIND_EDGE_2;
				FIND_EDGE_2:     if (rise_q) state_d = WRITE_START;
				WRITE_START:     state_d = FIND_EDGE_3;
				FIND_EDGE_3:     if (rise_q) state_d = COUNT_PERIOD;
				COUNT_PERIOD:    state_d = period_short ? FIND_EDGE_1 : COUNT_GEN_START;
				COUNT_GEN_START: state_d = WAIT_GEN_START;
				WAIT_GEN_START:  if (gen_hit_q) state_d = WAIT_STB_END;
				COUNT_STROBE:    state_d = WAIT_STB_END;
				WAIT_STB_END:    if (end_hit_q) state_d = COUNT_STROBE;
				default:         state_d = FIND_EDGE_1;
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			state_q <= FIND_EDGE_1;
		end else begin
			state_q <= state_d;
		end
	end

	// WRITE_START and COUNT_PERIOD both sit one cycle after their edge
	assign period_raw   = t_cnt_i - t_start_q;
	assign period_short = (period_raw < t_cnt_t'(MIN_PERIOD));

	always_ff @(posedge clk_i) begin
		if (state_q == WRITE_START) begin
			t_start_q <= t_cnt_i;
		end
		if ((state_q == COUNT_PERIOD) && !period_short) begin
			meas_period_o <= period_raw;
		end
	end

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			meas_valid_o <= 1'b0;
			err_o        <= 1'b0;
		end else begin
			meas_valid_o <= (state_q == COUNT_PERIOD) && !period_short && !rearm_i;
			if (rearm_i) begin
				err_o <= 1'b0;
			end else if (state_q == COUNT_PERIOD) begin
				err_o <= period_short;
			end
		end
	end

	// ------------------------------
	// deadline adders
	// ------------------------------
	// first deadline from the current time, later ones from the previous deadline
	assign gen_launch = (state_q == COUNT_GEN_START);
	assign end_launch = (state_q == COUNT_GEN_START) || (state_q == COUNT_STROBE);
	assign zh_launch  = (state_q == COUNT_STROBE);
	assign end_base   = (state_q == COUNT_STROBE) ? stb_end_res : t_cnt_i;
	assign gen_incr   = meas_period_o - t_cnt_t'(GEN_OFFSET);
	assign zh_incr    = meas_period_o - t_cnt_t'(ZERO_HOLD_CYCLES);

	pipelined_adder u_gen_start (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.a_i     (t_cnt_i),
		.b_i     (gen_incr),
		.valid_i (gen_launch),
		.valid_o (gen_valid),
		.res_o   (gen_start_res)
	);

	pipelined_adder u_stb_end (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.a_i     (end_base),
		.b_i     (meas_period_o),
		.valid_i (end_launch),
		.valid_o (),
		.res_o   (stb_end_res)
	);

	pipelined_adder u_zero_hold (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.a_i     (stb_end_res),
		.b_i     (zh_incr),
		.valid_i (zh_launch),
		.valid_o (zh_valid),
		.res_o   (zero_hold_res)
	);

	// ------------------------------
	// compares and strobe
	// ------------------------------
	assign gen_on = (state_q == WAIT_STB_END) || (state_q == COUNT_STROBE);

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			gen_armed_q <= 1'b0;
			zh_armed_q  <= 1'b0;
			gen_hit_q   <= 1'b0;
			end_hit_q   <= 1'b0;
			zh_hit_q    <= 1'b0;
		end else begin
			// a compare only runs once its adder has delivered a result
			gen_armed_q <= (state_q == WAIT_GEN_START) && (gen_armed_q || gen_valid);
			zh_armed_q  <= gen_on && (zh_armed_q || zh_valid);
			gen_hit_q   <= gen_armed_q && (state_q == WAIT_GEN_START)
				&& (t_cnt_i == gen_start_res);
			end_hit_q   <= (state_q == WAIT_STB_END) && (t_cnt_i == stb_end_res);
			zh_hit_q    <= zh_armed_q && (t_cnt_i == zero_hold_res);
		end
	end

	// rises at each period end, drops ZERO_HOLD_CYCLES before the next
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			stb_o <= 1'b0;
			rdy_o <= 1'b0;
		end else if (rearm_i) begin
			stb_o <= 1'b0;
			rdy_o <= 1'b0;
		end else if (gen_on) begin
			if (end_hit_q) begin
				stb_o <= 1'b1;
				rdy_o <= 1'b1;
			end else if (zh_hit_q) begin
				stb_o <= 1'b0;
			end
		end
	end

endmodule

// File: source/strobe_meter_top.sv
// four-channel frequency meter and strobe generator
// shared time base, strobe channels and the report collector
`timescale 1ns/1ns

module strobe_meter_top import stb_pkg::*; (
	input  logic              clk_i,
	input  logic              arstn_i,
	input  logic [N_CHAN-1:0] sig_i,
	input  logic [N_CHAN-1:0] rearm_i,
	input  logic              rpt_credit_i,
	output logic [N_CHAN-1:0] stb_o,
	output logic [N_CHAN-1:0] rdy_o,
	output logic [N_CHAN-1:0] err_o,
	output logic              rpt_valid_o,
	output chan_id_t          rpt_chan_o,
	output t_cnt_t            rpt_period_o
);

	t_cnt_t            t_cnt;
	logic [N_CHAN-1:0] meas_valid;
	t_cnt_t            meas_period [N_CHAN];

	time_base u_time_base (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.t_cnt_o (t_cnt)
	);

	// ------------------------------
	// strobe channels
	// ------------------------------
	for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
		strobe_channel u_chan (
			.clk_i         (clk_i),
			.arstn_i       (arstn_i),
			.t_cnt_i       (t_cnt),
			.sig_i         (sig_i[i]),
			.rearm_i       (rearm_i[i]),
			.stb_o         (stb_o[i]),
			.rdy_o         (rdy_o[i]),
			.err_o         (err_o[i]),
			.meas_valid_o  (meas_valid[i]),
			.meas_period_o (meas_period[i])
		);
	end

	period_report u_report (
		.clk_i         (clk_i),
		.arstn_i       (arstn_i),
		.meas_valid_i  (meas_valid),
		.meas_period_i (meas_period),
		.rpt_credit_i  (rpt_credit_i),
		.rpt_valid_o   (rpt_valid_o),
		.rpt_chan_o    (rpt_chan_o),
		.rpt_period_o  (rpt_period_o)
	);

endmodule

// File: source/time_base.sv
// free-running time base shared by all channels
// 32-bit count built from two 16-bit halves with a registered carry
`timescale 1ns/1ns

module time_base import stb_pkg::*; (
	input  logic   clk_i,
	input  logic   arstn_i,
	output t_cnt_t t_cnt_o
);

	logic [T_HALF_WIDTH-1:0] lo_q;
	logic [T_HALF_WIDTH-1:0] lo_next;
	logic [T_HALF_WIDTH-1:0] lo_d1_q;
	logic [T_HALF_WIDTH-1:0] hi_q;
	logic                    lo_carry;
	logic                    carry_q;

	assign {lo_carry, lo_next} = lo_q + 1'b1;

	// ------------------------------
	// low half and carry
	// ------------------------------
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			lo_q    <= '0;
			lo_d1_q <= '0;
			carry_q <= 1'b0;
		end else begin
			lo_q    <= lo_next;
			// low half delayed to line up with the high half
			lo_d1_q <= lo_q;
			carry_q <= lo_carry;
		end
	end

	// ------------------------------
	// high half and joined count
	// ------------------------------
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			hi_q    <= '0;
			t_cnt_o <= '0;
		end else begin
			hi_q    <= hi_q + {{(T_HALF_WIDTH-1){1'b0}}, carry_q};
			t_cnt_o <= {hi_q, lo_d1_q};
		end
	end

endmodule

// File: strobe_meter.f
source/stb_pkg.sv
source/time_base.sv
source/pipelined_adder.sv
source/strobe_channel.sv
source/period_report.sv
source/strobe_meter_top.sv
verification/strobe_meter_asserts.sv
verification/strobe_meter_tb.sv

// File: verification/strobe_meter_asserts.sv
// strobe meter assertions, bound to the top level
// credit limits of the report sender and the strobe low time
`timescale 1ns/1ns

module strobe_meter_asserts import stb_pkg::*; (
	input logic                    clk_i,
	input logic                    arstn_i,
	input logic [N_CHAN-1:0]       stb_i,
	input logic [N_CHAN-1:0]       rdy_i,
	input logic                    rpt_valid_i,
	input logic [CREDIT_WIDTH-1:0] credit_cnt_i
);

	// failure count, read by the testbench at the end
	int assert_fails = 0;

	valid_needs_credit : assert property (@(posedge clk_i) disable iff (!arstn_i)
		rpt_valid_i |-> (credit_cnt_i != '0))
	else begin
		$error("report sent with a credit count of zero");
		assert_fails++;
	end

	credit_in_range : assert property (@(posedge clk_i) disable iff (!arstn_i)
		credit_cnt_i <= CREDIT_WIDTH'(CREDIT_INIT))
	else begin
		$error("credit count %0d above its initial value", credit_cnt_i);
		assert_fails++;
	end

	// one low cycle per period, unless a rearm drops rdy at the same time
	for (genvar i = 0; i < N_CHAN; i++) begin : g_stb
		stb_low_once : assert property (@(posedge clk_i) disable iff (!arstn_i)
			(rdy_i[i] && !stb_i[i]) |=> (stb_i[i] || !rdy_i[i]))
		else begin
			$error("strobe %0d low for two cycles while ready", i);
			assert_fails++;
		end
	end

endmodule

// File: verification/strobe_meter_tb.sv
// testbench for the four-channel strobe meter
// square-wave inputs, report and strobe checks against a reference model
`timescale 1ns/1ns

module strobe_meter_tb import stb_pkg::*; ();

	localparam int N_TESTS         = 5;
	localparam int CYCLES_PER_TEST = 2000;

	logic              clk;
	logic              arstn;
	logic [N_CHAN-1:0] sig;
	logic [N_CHAN-1:0] rearm;
	logic              rpt_credit;
	logic [N_CHAN-1:0] stb;
	logic [N_CHAN-1:0] rdy;
	logic [N_CHAN-1:0] err;
	logic              rpt_valid;
	chan_id_t          rpt_chan;
	t_cnt_t            rpt_period;

	// half-period of each input in clock cycles
	int                half [N_CHAN];
	int                tgl_cnt [N_CHAN];
	logic [N_CHAN-1:0] exp_pend;
	t_cnt_t            exp_period [N_CHAN];
	int                rpt_total;
	int                rpt_start;
	int                chk_cnt;
	int                err_cnt;
	int                test_err_start;

	strobe_meter_top u_dut (
		.clk_i        (clk),
		.arstn_i      (arstn),
		.sig_i        (sig),
		.rearm_i      (rearm),
		.rpt_credit_i (rpt_credit),
		.stb_o        (stb),
		.rdy_o        (rdy),
		.err_o        (err),
		.rpt_valid_o  (rpt_valid),
		.rpt_chan_o   (rpt_chan),
		.rpt_period_o (rpt_period)
	);

	bind strobe_meter_top strobe_meter_asserts u_asserts (
		.clk_i        (clk_i),
		.arstn_i      (arstn_i),
		.stb_i        (stb_o),
		.rdy_i        (rdy_o),
		.rpt_valid_i  (rpt_valid_o),
		.credit_cnt_i (u_report.credit_cnt_q)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// reference and compare tasks
	// ------------------------------
	// both halves of each square wave have the same length
	function automatic t_cnt_t ref_period(input int half_cycles);
		return t_cnt_t'(2 * half_cycles);
	endfunction

	task automatic check_period(input string name, input t_cnt_t got, input t_cnt_t exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_chan(input chan_id_t got, input chan_id_t exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: rpt_chan_o got %0d expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		chk_cnt++;
		if (got != exp) begin
			err_cnt++;
			$display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	// square waves, toggled on the falling edge
	always @(negedge clk) begin
		for (int i = 0; i < N_CHAN; i++) begin
			if (tgl_cnt[i] + 1 >= half[i]) begin
				sig[i] <= ~sig[i];
				tgl_cnt[i] = 0;
			end else begin
				tgl_cnt[i] = tgl_cnt[i] + 1;
			end
		end
	end

	task automatic pick_halves(input logic [N_CHAN-1:0] mask);
		@(negedge clk);
		for (int i = 0; i < N_CHAN; i++) begin
			if (mask[i]) begin
				half[i] <= 10 + int'($urandom % 31);
			end
		end
	endtask

	// rpt_mask marks the channels that owe a report
	task automatic rearm_channels(input logic [N_CHAN-1:0] mask,
		input logic [N_CHAN-1:0] rpt_mask);
		@(negedge clk);
		for (int i = 0; i < N_CHAN; i++) begin
			if (rpt_mask[i]) begin
				exp_period[i] = ref_period(half[i]);
			end
		end
		exp_pend = exp_pend | rpt_mask;
		rearm <= mask;
		@(negedge clk);
		rearm <= '0;
	endtask

	task automatic wait_reports();
		while (exp_pend != '0) begin
			@(negedge clk);
		end
	endtask

	task automatic wait_ready(input logic [N_CHAN-1:0] mask);
		while ((rdy & mask) != mask) begin
			@(negedge clk);
		end
	endtask

	// low width and spacing of three strobe periods
	task automatic check_strobe(input int ch);
		t_cnt_t exp_p;
		int     low_run;
		int     gap;
		exp_p = ref_period(half[ch]);
		@(negedge clk);
		wait_ready(N_CHAN'(1) << ch);
		while (stb[ch]) begin
			@(negedge clk);
		end
		for (int n = 0; n < 3; n++) begin
			low_run = 0;
			while (!stb[ch]) begin
				low_run++;
				@(negedge clk);
			end
			check_period($sformatf("stb_o[%0d] low width", ch), t_cnt_t'(low_run),
				t_cnt_t'(ZERO_HOLD_CYCLES));
			gap = low_run;
			while (stb[ch]) begin
				gap++;
				@(negedge clk);
			end
			check_period($sformatf("stb_o[%0d] spacing", ch), t_cnt_t'(gap), exp_p);
		end
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %s, %0d errors", num, name,
			(err_cnt == test_err_start) ? "ok" : "failed", err_cnt - test_err_start);
		test_err_start = err_cnt;
	endtask

	// ------------------------------
	// report compare
	// ------------------------------
	always @(negedge clk) begin : compare_reports
		chan_id_t exp_ch;
		if (arstn && rpt_valid) begin
			rpt_total++;
			exp_ch = rpt_chan;
			// a report from a channel that owes none is held against one that does
			if (!exp_pend[rpt_chan]) begin
				for (int i = N_CHAN - 1; i >= 0; i--) begin
					if (exp_pend[i]) begin
						exp_ch = chan_id_t'(i);
					end
				end
			end
			if (exp_pend == '0) begin
				err_cnt++;
				$display("report from channel %0d arrived while none was expected", rpt_chan);
			end else begin
				check_chan(rpt_chan, exp_ch);
				check_period("rpt_period_o", rpt_period, exp_period[exp_ch]);
				exp_pend[exp_ch] = 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (N_TESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("timeout: the run did not end within %0d cycles", N_TESTS * CYCLES_PER_TEST);
		$display("CHECKS FAILED");
		$finish;
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		void'($urandom(75666));
		arstn          = 1'b0;
		sig            = '0;
		rearm          = '0;
		rpt_credit     = 1'b1;
		exp_pend       = '0;
		rpt_total      = 0;
		chk_cnt        = 0;
		err_cnt        = 0;
		test_err_start = 0;
		for (int i = 0; i < N_CHAN; i++) begin
			half[i]    = 20;
			tgl_cnt[i] = 0;
		end
		repeat (2) @(negedge clk);
		check_flag("outputs after reset", |{stb, rdy, err, rpt_valid}, 1'b0);
		arstn = 1'b1;

		pick_halves('1);
		rearm_channels('1, '1);
		wait_reports();
		// any extra report is flagged by the compare process
		repeat (100) @(negedge clk);
		check_count("report count", rpt_total, N_CHAN);
		finish_test(1, "one report per channel");

		for (int i = 0; i < N_CHAN; i++) begin
			check_strobe(i);
		end
		finish_test(2, "strobe shape and spacing");

		@(negedge clk);
		half[2] <= MIN_PERIOD / 4;
		rearm_channels(4'b0100, '0);
		// several short periods, enough for a full measurement
		repeat (150) @(negedge clk);
		check_flag("err_o[2]", err[2], 1'b1);
		check_flag("rdy_o[2]", rdy[2], 1'b0);
		check_count("report count", rpt_total, N_CHAN);
		finish_test(3, "period below minimum");

		@(negedge clk);
		rpt_credit <= 1'b0;
		rpt_start = rpt_total;
		pick_halves('1);
		rearm_channels('1, '1);
		wait_reports();
		pick_halves('1);
		rearm_channels('1, '1);
		wait_ready('1);
		repeat (20) @(negedge clk);
		check_count("reports without credit", rpt_total - rpt_start, CREDIT_INIT);
		check_count("reports held back", $countones(exp_pend), N_CHAN);
		rpt_credit <= 1'b1;
		wait_reports();
		finish_test(4, "credit back-pressure");

		pick_halves(4'b0010);
		rearm_channels(4'b0010, 4'b0010);
		wait_reports();
		check_strobe(1);
		finish_test(5, "rearm with a new period");

		err_cnt += u_dut.u_asserts.assert_fails;
		$display("tests %0d, checks %0d, errors %0d", N_TESTS, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
